// ==== verilog/red_track_consts.svh ====
`ifndef RED_TRACK_CONSTS_SVH
`define RED_TRACK_CONSTS_SVH

// image geometry, qqvga/2
`define IMG_COLS 80
`define IMG_ROWS 60
`define IMG_PXLS 4800   // cols * rows

// frame buffer address and word width
`define NB_ADDR 13      // 4800 -> 2^13
`define NB_PXL 12       // rgb444

// inner window used for the histogram, 64 x 48
`define WIN_COL_LO 8
`define WIN_COL_HI 71
`define WIN_ROW_LO 6
`define WIN_ROW_HI 53

// a red pixel needs green and blue strictly below these
`define THR_GREEN 9
`define THR_BLUE 9

`endif

// ==== verilog/red_track_pkg.sv ====
`default_nettype none

// shared types for the red object tracker
package red_track_pkg;

  // color filter select, one bit per color: r g b
  typedef enum logic [2:0] {
    filt_none = 3'b000, // pass everything
    filt_b    = 3'b001,
    filt_g    = 3'b010,
    filt_gb   = 3'b011,
    filt_r    = 3'b100, // red rule, not just the msb
    filt_rb   = 3'b101,
    filt_rg   = 3'b110,
    filt_rgb  = 3'b111
  } filter_mode_e;

  // apb register map, decoded from paddr[3:0]
  typedef enum logic [3:0] {
    reg_ctrl      = 4'h0, // rw, filter mode in bits 2:0
    reg_peak_col  = 4'h4, // ro, raw column of the peak
    reg_peak_cnt  = 4'h8, // ro, red pixels in that column
    reg_frame_cnt = 4'hC  // ro, finished frames
  } apb_reg_e;

endpackage : red_track_pkg

`default_nettype wire

// ==== verilog/frame_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

// frame buffer, one write port and one read port
// read data comes out one clock after raddr
module frame_ram #(
  parameter int depth = 4800,
  parameter int width = 12
) (
  input  wire                      clk,
  input  wire                      we,
  input  wire  [$clog2(depth)-1:0] waddr,
  input  wire  [width-1:0]         wdata,
  input  wire  [$clog2(depth)-1:0] raddr,
  output logic [width-1:0]         rdata
);

  logic [width-1:0] mem [depth]; // pixel storage

  // write side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, maps onto block ram
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule : frame_ram

`default_nettype wire

// ==== verilog/color_proc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "red_track_consts.svh"

// scans the source frame in raster order, writes a filtered copy
// and finds the window column with the most red pixels
module color_proc (
  input  wire                             clk,
  input  wire                             rst,
  input  wire red_track_pkg::filter_mode_e filter_mode,
  output logic [`NB_ADDR-1:0]             src_addr,
  input  wire  [`NB_PXL-1:0]              src_pxl,
  output logic                            proc_we,
  output logic [`NB_ADDR-1:0]             proc_addr,
  output logic [`NB_PXL-1:0]              proc_pxl,
  output logic                            frame_done,
  output logic [6:0]                      peak_col,
  output logic [5:0]                      peak_cnt
);

  import red_track_pkg::*;

  logic [`NB_ADDR-1:0] cnt_pxl;  // address being issued
  logic [6:0]          src_col;  // column of cnt_pxl
  logic [5:0]          src_row;  // row of cnt_pxl
  logic [6:0]          px_col;   // column of the pixel coming back
  logic [5:0]          px_row;   // row of the pixel coming back
  logic                end_frm;
  logic                end_ln;
  filter_mode_e        mode_q;   // mode for the current frame

  logic                red_ok;
  logic                grn_ok;
  logic                blu_ok;
  logic                pass;

  logic [5:0]          hist [64]; // red count per window column
  logic                in_win;
  logic [5:0]          bin;
  logic [5:0]          hist_inc;

  assign end_frm = (cnt_pxl == `NB_ADDR'(`IMG_PXLS - 1));
  assign end_ln  = (src_col == 7'(`IMG_COLS - 1));

  // pixel counter, one address per cycle, wraps at 4799
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_pxl   <= '0;
      proc_addr <= '0;
      proc_we   <= 1'b0;
    end else begin
      proc_we   <= 1'b1;      // first write is stale, rewritten next frame
      proc_addr <= cnt_pxl;   // ram read latency
      if (end_frm) cnt_pxl <= '0;
      else         cnt_pxl <= cnt_pxl + 1'b1;
    end
  end

  assign src_addr = cnt_pxl;

  // column and row of the issued address
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      src_col <= '0;
      src_row <= '0;
    end else begin
      if (end_ln) src_col <= '0;
      else        src_col <= src_col + 1'b1;
      if (end_frm)     src_row <= '0;
      else if (end_ln) src_row <= src_row + 1'b1;
    end
  end

  // same position, one cycle later, lined up with src_pxl
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      px_col <= '0;
      px_row <= '0;
    end else begin
      px_col <= src_col;
      px_row <= src_row;
    end
  end

  // take the new filter mode only at the start of a frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mode_q <= filt_none;
    end else if (cnt_pxl == '0) begin
      mode_q <= filter_mode;
    end
  end

  // per color tests on the returning pixel
  assign red_ok = src_pxl[11] && (src_pxl[7:4] < 4'(`THR_GREEN))
                  && (src_pxl[3:0] < 4'(`THR_BLUE));
  assign grn_ok = src_pxl[7];
  assign blu_ok = src_pxl[3];

  // every selected color has to pass, otherwise black
  always_comb begin
    pass = 1'b0;
    unique case (mode_q)
      filt_none: pass = 1'b1;
      filt_b:    pass = blu_ok;
      filt_g:    pass = grn_ok;
      filt_gb:   pass = grn_ok & blu_ok;
      filt_r:    pass = red_ok;
      filt_rb:   pass = red_ok & blu_ok;
      filt_rg:   pass = red_ok & grn_ok;
      filt_rgb:  pass = red_ok & grn_ok & blu_ok;
    endcase
    proc_pxl = pass ? src_pxl : '0;
  end

  // last pixel of the frame is on the write port now
  assign frame_done = (proc_addr == `NB_ADDR'(`IMG_PXLS - 1));

  // inner window, cols 8..71 and rows 6..53
  assign in_win = (px_col >= 7'(`WIN_COL_LO)) && (px_col <= 7'(`WIN_COL_HI))
               && (px_row >= 6'(`WIN_ROW_LO)) && (px_row <= 6'(`WIN_ROW_HI));
  assign bin      = 6'(px_col - 7'(`WIN_COL_LO)); // col 8 -> bin 0
  assign hist_inc = hist[bin] + 6'd1;             // max 48, no wrap

  // histogram and running peak, both cleared at frame end
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        hist[i] <= '0;
      end
      peak_col <= '0;
      peak_cnt <= '0;
    end else if (frame_done) begin
      for (int i = 0; i < 64; i++) begin
        hist[i] <= '0;
      end
      peak_col <= '0; // 0 means no red pixel seen
      peak_cnt <= '0;
    end else if (in_win && red_ok) begin
      hist[bin] <= hist_inc;
      // strictly greater, so the earliest column keeps a tie
      if (hist_inc > peak_cnt) begin
        peak_cnt <= hist_inc;
        peak_col <= px_col;   // raw column, not the bin
      end
    end
  end

endmodule : color_proc

`default_nettype wire

// ==== verilog/apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

// apb slave: filter control, latched peak status, frame counter
// zero wait states
module apb_regs (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire  [31:0]                  paddr,
  input  wire  [31:0]                  pwdata,
  output logic [31:0]                  prdata,
  output logic                         pready,
  output logic                         pslverr,
  output red_track_pkg::filter_mode_e  filter_mode,
  input  wire                          frame_done,
  input  wire  [6:0]                   peak_col,
  input  wire  [5:0]                   peak_cnt
);

  import red_track_pkg::*;

  apb_reg_e    reg_sel;
  logic        acc;         // access phase
  logic        reg_err;     // unmapped or write to read only
  logic [31:0] rd_data;
  logic [6:0]  peak_col_q;
  logic [5:0]  peak_cnt_q;
  logic [15:0] frame_cnt;

  assign reg_sel = apb_reg_e'(paddr[3:0]);
  assign acc     = psel & penable;

  // address decode and read mux
  always_comb begin
    reg_err = 1'b0;
    rd_data = '0;
    if (paddr[31:4] != '0) begin
      reg_err = 1'b1;              // beyond the register block
    end else begin
      case (reg_sel)
        reg_ctrl:      rd_data = {29'd0, filter_mode};
        reg_peak_col: begin
          rd_data = {25'd0, peak_col_q};
          reg_err = pwrite;
        end
        reg_peak_cnt: begin
          rd_data = {26'd0, peak_cnt_q};
          reg_err = pwrite;
        end
        reg_frame_cnt: begin
          rd_data = {16'd0, frame_cnt};
          reg_err = pwrite;
        end
        default:       reg_err = 1'b1; // holes in the map
      endcase
    end
  end

  assign prdata  = (psel & ~pwrite) ? rd_data : '0;
  assign pready  = 1'b1;            // never stalls
  assign pslverr = acc & reg_err;

  // control register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      filter_mode <= filt_none;
    end else if (acc && pwrite && !reg_err && (reg_sel == reg_ctrl)) begin
      filter_mode <= filter_mode_e'(pwdata[2:0]);
    end
  end

  // status, captured once per frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      peak_col_q <= '0;
      peak_cnt_q <= '0;
      frame_cnt  <= '0;
    end else if (frame_done) begin
      peak_col_q <= peak_col;
      peak_cnt_q <= peak_cnt;
      frame_cnt  <= frame_cnt + 16'd1; // wraps at 64k frames
    end
  end

endmodule : apb_regs

`default_nettype wire

// ==== verilog/red_track_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "red_track_consts.svh"

// red tracker top: camera -> src_ram -> color_proc -> proc_ram -> display
module red_track_top (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 cam_we,
  input  wire  [`NB_ADDR-1:0] cam_addr,
  input  wire  [`NB_PXL-1:0]  cam_pxl,
  input  wire  [`NB_ADDR-1:0] disp_addr,
  output logic [`NB_PXL-1:0]  disp_pxl,
  input  wire                 psel,
  input  wire                 penable,
  input  wire                 pwrite,
  input  wire  [31:0]         paddr,
  input  wire  [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr
);

  import red_track_pkg::*;

  filter_mode_e        filter_mode;
  logic [`NB_ADDR-1:0] src_addr;   // scan read address
  logic [`NB_PXL-1:0]  src_pxl;
  logic                proc_we;
  logic [`NB_ADDR-1:0] proc_addr;
  logic [`NB_PXL-1:0]  proc_pxl;   // filtered pixel
  logic                frame_done;
  logic [6:0]          peak_col;
  logic [5:0]          peak_cnt;

  // camera writes, color processor reads
  frame_ram #(.depth(`IMG_PXLS), .width(`NB_PXL)) src_ram (
    .clk(clk), .we(cam_we), .waddr(cam_addr), .wdata(cam_pxl),
    .raddr(src_addr), .rdata(src_pxl)
  );

  // color processor writes, display reads
  frame_ram #(.depth(`IMG_PXLS), .width(`NB_PXL)) proc_ram (
    .clk(clk), .we(proc_we), .waddr(proc_addr), .wdata(proc_pxl),
    .raddr(disp_addr), .rdata(disp_pxl)
  );

  color_proc color_proc_i (
    .clk(clk), .rst(rst), .filter_mode(filter_mode),
    .src_addr(src_addr), .src_pxl(src_pxl),
    .proc_we(proc_we), .proc_addr(proc_addr), .proc_pxl(proc_pxl),
    .frame_done(frame_done), .peak_col(peak_col), .peak_cnt(peak_cnt)
  );

  apb_regs apb_regs_i (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .filter_mode(filter_mode),
    .frame_done(frame_done), .peak_col(peak_col), .peak_cnt(peak_cnt)
  );

endmodule : red_track_top

`default_nettype wire

// ==== testbench/red_track_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "red_track_consts.svh"

// concurrent checks on the scan pipeline and the apb slave response
module red_track_assertions (
  input wire                clk,
  input wire                rst,
  input wire [`NB_ADDR-1:0] src_addr,
  input wire                proc_we,
  input wire [`NB_ADDR-1:0] proc_addr,
  input wire                frame_done,
  input wire                psel,
  input wire                penable,
  input wire                pslverr
);

  int n_fail = 0; // failed assertions so far

  // no writes into the processed buffer while reset is held
  we_low_in_reset: assert property (@(posedge clk) rst |-> !proc_we)
    else begin $error("proc_we high during reset"); n_fail++; end

  // write address is the read address one clock late
  proc_addr_delay: assert property (@(posedge clk) disable iff (rst)
    proc_addr == $past(src_addr))
    else begin $error("proc_addr does not follow src_addr"); n_fail++; end

  // frame end only after the last address went out
  done_after_last: assert property (@(posedge clk) disable iff (rst)
    frame_done |-> $past(src_addr) == `NB_ADDR'(`IMG_PXLS - 1))
    else begin $error("frame_done without src_addr 4799 before it"); n_fail++; end

  // error response only in an access phase
  err_in_access: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> (psel && penable))
    else begin $error("pslverr outside an access phase"); n_fail++; end

endmodule : red_track_assertions

`default_nettype wire

// ==== testbench/red_track_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "red_track_consts.svh"

module red_track_tb;

  import red_track_pkg::*;

  localparam int clk_period = 8;
  localparam int frames_waited = 8 * 4 + 2 * 3 + 1; // mode: load, 2 frames, readout

  logic                clk = 1'b0;
  logic                rst;
  logic                cam_we;
  logic [`NB_ADDR-1:0] cam_addr;
  logic [`NB_PXL-1:0]  cam_pxl;
  logic [`NB_ADDR-1:0] disp_addr;
  logic [`NB_PXL-1:0]  disp_pxl;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [31:0]         paddr;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;

  logic [`NB_PXL-1:0]  img [`IMG_PXLS]; // copy of what the camera wrote
  filter_mode_e        cur_mode;          // mode the readout expects
  logic                disp_rd = 1'b0;    // display read issued this cycle
  logic                rd_vld_q = 1'b0;
  logic [`NB_ADDR-1:0] rd_addr_q;
  int                  n_pxl_seen = 0;
  int                  n_checks = 0;

  red_track_top red_track_top_i (
    .clk(clk), .rst(rst), .cam_we(cam_we), .cam_addr(cam_addr), .cam_pxl(cam_pxl),
    .disp_addr(disp_addr), .disp_pxl(disp_pxl),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  // scan and bus checker on the top, sees both color_proc and apb_regs nets
  bind red_track_top red_track_assertions red_track_assertions_i (
    .clk(clk), .rst(rst), .src_addr(src_addr), .proc_we(proc_we), .proc_addr(proc_addr),
    .frame_done(frame_done), .psel(psel), .penable(penable), .pslverr(pslverr)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk; // posedge at 4, 12, ...
  end

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_pxl(input string name, input logic [`NB_PXL-1:0] exp,
                           input logic [`NB_PXL-1:0] got);
    n_checks++;
    if (got !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_peak(input logic [6:0] exp_col, input logic [5:0] exp_cnt,
                            input logic [6:0] got_col, input logic [5:0] got_cnt);
    n_checks++;
    if (got_col !== exp_col || got_cnt !== exp_cnt) begin
      $display("** Error: peak_col expected 0x%h, got 0x%h; peak_cnt expected 0x%h, got 0x%h",
               exp_col, got_col, exp_cnt, got_cnt);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] got);
    n_checks++;
    if (got !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    n_checks++;
    if (got !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  // red: msb of red set, green and blue under threshold
  function automatic logic is_red(input logic [`NB_PXL-1:0] pxl);
    return pxl[11] && (pxl[7:4] < `THR_GREEN) && (pxl[3:0] < `THR_BLUE);
  endfunction

  // mode bits r g b, each set bit adds one test that must hold
  function automatic logic [`NB_PXL-1:0] ref_filter(input logic [`NB_PXL-1:0] pxl,
                                                    input filter_mode_e mode);
    logic keep;
    keep = 1'b1;
    if (mode[2] && !is_red(pxl)) keep = 1'b0;
    if (mode[1] && !pxl[7]) keep = 1'b0;
    if (mode[0] && !pxl[3]) keep = 1'b0;
    return keep ? pxl : '0;
  endfunction

  // raster walk over img, strictly higher count takes the peak
  function automatic void ref_peak(output logic [6:0] col, output logic [5:0] cnt);
    int hist [64];
    int best;
    best = 0;
    col = '0;
    foreach (hist[i]) hist[i] = 0;
    for (int r = `WIN_ROW_LO; r <= `WIN_ROW_HI; r++) begin
      for (int c = `WIN_COL_LO; c <= `WIN_COL_HI; c++) begin
        if (is_red(img[r * `IMG_COLS + c])) begin
          hist[c - `WIN_COL_LO]++;
          if (hist[c - `WIN_COL_LO] > best) begin
            best = hist[c - `WIN_COL_LO];
            col = 7'(c);
          end
        end
      end
    end
    cnt = 6'(best);
  endfunction

  // one apb transfer, sampled mid access phase
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    #(clk_period / 4);
    check_bit("pready", 1'b1, pready); // zero wait states, ready in every access
    rdata = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] rd_ignored;
    apb_xfer(1'b1, addr, data, rd_ignored, err);
  endtask

  // push img into the source buffer, one pixel per clock
  task automatic write_camera();
    for (int i = 0; i < `IMG_PXLS; i++) begin
      @(negedge clk);
      cam_we = 1'b1;
      cam_addr = `NB_ADDR'(i);
      cam_pxl = img[i];
    end
    @(negedge clk);
    cam_we = 1'b0;
  endtask

  task automatic put_red(input int col, input int row_lo, input int row_hi);
    for (int r = row_lo; r <= row_hi; r++) begin
      img[r * `IMG_COLS + col] = {1'b1, 3'($urandom), 4'($urandom % 9), 4'($urandom % 9)};
    end
  endtask

  // frame_cnt has to move by n, the first step may end a partial frame
  task automatic wait_frames(input int n);
    logic [31:0] start;
    logic [31:0] now;
    logic err;
    apb_read(32'(reg_frame_cnt), start, err);
    now = start;
    while (now - start < 32'(n)) begin
      apb_read(32'(reg_frame_cnt), now, err);
    end
  endtask

  // sweep the display port, the compare process checks each pixel
  task automatic read_display();
    n_pxl_seen = 0;
    for (int a = 0; a < `IMG_PXLS; a++) begin
      @(negedge clk);
      disp_rd = 1'b1;
      disp_addr = `NB_ADDR'(a);
    end
    @(negedge clk);
    disp_rd = 1'b0;
    @(negedge clk); // last pixel compared on the previous edge
    if (n_pxl_seen != `IMG_PXLS) begin
      $display("only %0d of %0d display pixels were compared", n_pxl_seen, `IMG_PXLS);
      abort_run();
    end
  endtask

  // read address as the ram saw it, data compared half a clock later
  always @(posedge clk) begin
    rd_vld_q <= disp_rd;
    rd_addr_q <= disp_addr;
  end

  always @(negedge clk) begin
    if (rd_vld_q) begin
      check_pxl($sformatf("disp_pxl[%0d]", rd_addr_q),
                ref_filter(img[rd_addr_q], cur_mode), disp_pxl);
      n_pxl_seen++;
    end
  end

  initial begin
    #((frames_waited + 4) * `IMG_PXLS * clk_period);
    $display("timeout: run still busy after %0d frame times", frames_waited + 4);
    abort_run();
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] rd2;
    logic        err;
    logic [6:0]  exp_col;
    logic [5:0]  exp_cnt;
    void'($urandom(66));
    rst = 1'b1;
    cam_we = 1'b0;
    cam_addr = '0;
    cam_pxl = '0;
    disp_addr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    cur_mode = filt_none;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reset value and error responses
    apb_read(32'(reg_ctrl), rd, err);
    check_reg("ctrl", 32'(filt_none), rd);
    check_bit("pslverr on ctrl read", 1'b0, err);
    apb_read(32'h10, rd, err);
    check_bit("pslverr on unmapped read", 1'b1, err);
    apb_read(32'h6, rd, err); // hole inside the block
    check_bit("pslverr on hole read", 1'b1, err);
    apb_write(32'(reg_peak_col), 32'h5, err);
    check_bit("pslverr on peak_col write", 1'b1, err);

    // all eight filters, fresh image each time
    for (int m = 0; m < 8; m++) begin
      for (int i = 0; i < `IMG_PXLS; i++) img[i] = 12'($urandom);
      write_camera();
      cur_mode = filter_mode_e'(m);
      apb_write(32'(reg_ctrl), 32'(m), err);
      check_bit("pslverr on ctrl write", 1'b0, err);
      wait_frames(2);
      read_display();
    end

    // red columns in and out of the window, three of them tied at 20
    for (int i = 0; i < `IMG_PXLS; i++) img[i] = 12'($urandom) & 12'h7ff;
    put_red(3, 10, 40);   // left of window
    put_red(75, 6, 53);   // right of window
    put_red(20, 0, 5);    // above window
    put_red(20, 10, 29);
    put_red(40, 6, 25);   // reaches 20 first
    put_red(8, 34, 53);
    put_red(71, 40, 53);
    write_camera();
    wait_frames(2);
    ref_peak(exp_col, exp_cnt);
    apb_read(32'(reg_peak_col), rd, err);
    apb_read(32'(reg_peak_cnt), rd2, err);
    check_peak(exp_col, exp_cnt, rd[6:0], rd2[5:0]);

    // green at or above threshold everywhere, so nothing counts
    for (int i = 0; i < `IMG_PXLS; i++) img[i] = 12'($urandom) | 12'h090;
    write_camera();
    wait_frames(2);
    apb_read(32'(reg_peak_col), rd, err);
    apb_read(32'(reg_peak_cnt), rd2, err);
    check_peak(7'd0, 6'd0, rd[6:0], rd2[5:0]);

    // two samples exactly one scan apart
    apb_read(32'(reg_frame_cnt), rd, err);
    repeat (`IMG_PXLS - 3) @(negedge clk);
    apb_read(32'(reg_frame_cnt), rd2, err);
    check_reg("frame_cnt step", rd + 32'd1, rd2);

    if (n_checks > 0 && red_track_top_i.red_track_assertions_i.n_fail == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("assertion failures seen or no checks run");
      abort_run();
    end
  end

endmodule : red_track_tb

`default_nettype wire

// ==== red_track_top.f ====
+incdir+verilog
verilog/red_track_pkg.sv
verilog/frame_ram.sv
verilog/color_proc.sv
verilog/apb_regs.sv
verilog/red_track_top.sv
testbench/red_track_assertions.sv
testbench/red_track_tb.sv

// ==== Makefile ====
# Verilator build and run for the red tracker testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = red_track_tb
FLIST    = red_track_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
